/* rsa_avm_top.f */
src/avm_regs_pkg.sv
src/rsa_pkg.sv
src/rsa_prep.sv
src/rsa_mont.sv
src/rsa_core.sv
src/rsa_avm_wrapper.sv
src/rsa_avm_top.sv
bench/tb_clkgen.sv
bench/tb_rsa_avm_top.sv

/* Makefile */
# Verilator build and run for the RSA Avalon accelerator

VERILATOR ?= verilator
TOP       ?= tb_rsa_avm_top
FILELIST  ?= rsa_avm_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_rsa_avm_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rsa_avm_top
    import avm_regs_pkg::*;
    import rsa_pkg::*;
();

    localparam logic [31:0] seed            = 32'h39e036be;
    localparam int          msg_count       = 7;
    localparam longint      watchdog_cycles = longint'(msg_count) * (70000 + 96 * 40);

    logic        avm_clk;
    logic        por_rst;
    logic        test_rst;
    logic        avm_rst;
    logic [4:0]  avm_address;
    logic        avm_read;
    logic [31:0] avm_readdata = 32'd0;
    logic        avm_write;
    logic [31:0] avm_writedata;
    logic        avm_waitrequest = 1'b0;

    logic [7:0]  rx_q[$];          // bytes waiting in the peripheral RX
    logic [7:0]  tx_log[$];        // bytes the bus model saw on TX
    int          rx_rd = 0;        // next RX byte handed to the DUT
    logic        rand_stall;       // random waitrequest on
    logic        gate_tx;          // tx_ok only now and then
    logic        rx_seen = 1'b0;
    logic        wr_pending = 1'b0;
    logic [31:0] wr_held = 32'd0;
    logic [31:0] bus_lcg = seed;
    logic [31:0] data_lcg;
    int          errors;
    int          checks;
    int          bus_errors = 0;
    int          bus_checks = 0;
    string       test_name;

    assign avm_rst = por_rst | test_rst;

    tb_clkgen u_clkgen (
        .clk (avm_clk),
        .rst (por_rst)
    );

    rsa_avm_top u_dut (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic rsa_word_t rand_word();
        rsa_word_t w;
        int        i;
        w = '0;
        for (i = 0; i < rsa_width / 32; i++) begin
            data_lcg = lcg_step(data_lcg);
            w = {w[rsa_width-33:0], data_lcg};
        end
        return w;
    endfunction

    // odd and below 2^247 with bit 246 set so it is never tiny
    function automatic rsa_word_t rand_modulus();
        rsa_word_t n;
        n = rand_word() >> 9;
        n[246] = 1'b1;
        n[0] = 1'b1;
        return n;
    endfunction

    // right-to-left square and multiply on double width values
    function automatic rsa_word_t mod_exp(input rsa_word_t base, input rsa_word_t e,
                                          input rsa_word_t m);
        logic [511:0] r;
        logic [511:0] b;
        logic [511:0] mm;
        int           i;
        mm = {256'd0, m};
        r  = 512'd1 % mm;
        b  = {256'd0, base} % mm;
        for (i = 0; i < rsa_width; i++) begin
            if (e[i]) r = (r * b) % mm;
            b = (b * b) % mm;
        end
        return r[rsa_width-1:0];
    endfunction

    task automatic show_mismatch(input string name, input logic [255:0] expected,
                                 input logic [255:0] actual);
        $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    task automatic note_failure(input string name, input string what);
        $display("** Error %s: %s", name, what);
    endtask

    // peripheral model driving its outputs on the falling edge
    always @(negedge avm_clk) begin
        logic        stall_now;
        logic        tx_ok;
        logic        rx_ok;
        logic [31:0] rdata;
        bus_lcg   = lcg_step(bus_lcg);
        stall_now = rand_stall && bus_lcg[31];
        tx_ok     = !gate_tx || (bus_lcg[30:29] != 2'b00);
        rx_ok     = (rx_rd < rx_q.size());
        rdata     = 32'd0;
        if (avm_rst) begin
            rx_seen    = 1'b0;
            wr_pending = 1'b0;
            stall_now  = 1'b0;
        end else begin
            if (wr_pending) begin
                bus_checks++;
                assert (avm_write && avm_writedata == wr_held) else begin
                    bus_errors++;
                    show_mismatch({test_name, " held writedata"}, wr_held, avm_writedata);
                end
            end
            if (!rx_seen) begin
                bus_checks++;
                assert (!avm_write && (!avm_read || avm_address == status_base)) else begin
                    bus_errors++;
                    note_failure(test_name, "bus access other than a STATUS read before rx_ok");
                end
            end
            if (avm_read) begin
                bus_checks++;
                assert (avm_address == status_base || avm_address == rx_base) else begin
                    bus_errors++;
                    note_failure(test_name, "read from an unmapped address");
                end
                if (avm_address == status_base) begin
                    rdata[rx_ok_bit] = rx_ok;
                    rdata[tx_ok_bit] = tx_ok;
                    if (!stall_now && rx_ok) rx_seen = 1'b1;
                end else if (avm_address == rx_base) begin
                    bus_checks++;
                    assert (rx_ok) else begin
                        bus_errors++;
                        note_failure(test_name, "RX read while no RX byte is waiting");
                    end
                    if (rx_ok) begin
                        rdata = {24'd0, rx_q[rx_rd]};
                        if (!stall_now) rx_rd++;  // byte consumed on acceptance
                    end
                end
            end
            if (avm_write) begin
                bus_checks++;
                assert (avm_address == tx_base) else begin
                    bus_errors++;
                    note_failure(test_name, "write to an address other than TX");
                end
                if (avm_address == tx_base && !stall_now) begin
                    tx_log.push_back(avm_writedata[7:0]);
                end
            end
            wr_pending = avm_write && stall_now;
            wr_held    = avm_writedata;
        end
        avm_waitrequest = stall_now;
        avm_readdata    = rdata;
    end

    task automatic push_word(input rsa_word_t v);
        int k;
        for (k = rsa_bytes - 1; k >= 0; k--) begin
            rx_q.push_back(v[8*k +: 8]);  // msb first
        end
    endtask

    task automatic check_idle_bus(input string name);
        checks++;
        assert (!avm_read && !avm_write && avm_address == status_base) else begin
            errors++;
            note_failure(name, "bus not idle on STATUS during reset");
        end
    endtask

    task automatic apply_reset(input logic stall_on, input logic gate_on);
        @(negedge avm_clk);
        test_rst   = 1'b1;
        rand_stall = stall_on;
        gate_tx    = gate_on;
        @(negedge avm_clk);
        check_idle_bus("reset");
        repeat (7) @(negedge avm_clk);
        test_rst = 1'b0;
    endtask

    // feeds key and ciphertext and checks the 31 TX bytes that come back
    task automatic run_message(input string name, input rsa_word_t n, input rsa_word_t d,
                               input rsa_word_t c, input rsa_word_t expect_pt,
                               input logic with_key);
        int first;
        int k;
        test_name = name;
        @(posedge avm_clk);
        first = tx_log.size();
        if (with_key) begin
            push_word(n);
            push_word(d);
        end
        push_word(c);
        while (tx_log.size() < first + rsa_out_bytes) @(posedge avm_clk);
        repeat (8) @(posedge avm_clk);  // nothing may follow the last byte
        checks++;
        assert (tx_log.size() == first + rsa_out_bytes) else begin
            errors++;
            show_mismatch({name, " byte count"}, rsa_out_bytes, tx_log.size() - first);
        end
        for (k = 0; k < rsa_out_bytes; k++) begin
            checks++;
            assert (tx_log[first+k] == expect_pt[8*(rsa_out_bytes-1-k) +: 8]) else begin
                errors++;
                show_mismatch($sformatf("%s byte %0d", name, k),
                              expect_pt[8*(rsa_out_bytes-1-k) +: 8], tx_log[first+k]);
            end
        end
    endtask

    initial begin
        rsa_word_t n1;
        rsa_word_t d1;
        rsa_word_t c1;
        rsa_word_t n2;
        rsa_word_t d2;
        rsa_word_t c2;
        int        k;
        int        status_reads;
        test_rst   = 1'b0;
        rand_stall = 1'b0;
        gate_tx    = 1'b0;
        data_lcg   = seed;
        errors     = 0;
        checks     = 0;
        test_name  = "reset";

        @(negedge avm_clk);
        check_idle_bus("power-on reset");
        while (por_rst) @(negedge avm_clk);

        // only STATUS polling while the RX queue is empty
        test_name    = "idle_poll";
        status_reads = 0;
        repeat (64) begin
            @(negedge avm_clk);
            if (avm_read && avm_address == status_base) status_reads++;
        end
        checks++;
        assert (status_reads > 0) else begin
            errors++;
            note_failure(test_name, "no STATUS polling after reset");
        end

        n1 = rand_modulus();
        d1 = rand_word();
        c1 = rand_word() % n1;
        run_message("single", n1, d1, c1, mod_exp(c1, d1, n1), 1'b1);

        // three ciphertexts under a key sent once
        apply_reset(1'b0, 1'b0);
        n2 = rand_modulus();
        d2 = rand_word();
        for (k = 0; k < 3; k++) begin
            c2 = rand_word() % n2;
            run_message($sformatf("loop%0d", k), n2, d2, c2, mod_exp(c2, d2, n2),
                        (k == 0));
        end

        apply_reset(1'b1, 1'b1);
        run_message("backpressure", n1, d1, c1, mod_exp(c1, d1, n1), 1'b1);

        apply_reset(1'b0, 1'b0);
        run_message("d_one", n1, rsa_word_t'(1), c1, c1, 1'b1);
        apply_reset(1'b0, 1'b0);
        run_message("d_zero", n1, rsa_word_t'(0), c1, rsa_word_t'(1), 1'b1);

        $display("checks: %0d, errors: %0d", checks + bus_checks, errors + bus_errors);
        if (errors + bus_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // budget per message covers the core run plus all byte transfers
    initial begin
        repeat (watchdog_cycles) @(posedge avm_clk);
        $display("watchdog: run did not finish within %0d cycles in test %s",
                 watchdog_cycles, test_name);
        $display("checks: %0d, errors: %0d", checks + bus_checks, errors + bus_errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // power-on reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* src/rsa_avm_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rsa_avm_top
    import rsa_pkg::*;
(
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest
);

    logic      start;
    logic      done;
    rsa_job_t  job;
    rsa_word_t result;

    rsa_avm_wrapper u_wrapper (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .start           (start),
        .job             (job),
        .done            (done),
        .result          (result)
    );

    rsa_core u_core (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (start),
        .job     (job),
        .result  (result),
        .done    (done)
    );

endmodule

`default_nettype wire

/* src/rsa_avm_wrapper.sv */
`timescale 1ns/10ps
`default_nettype none

module rsa_avm_wrapper
    import avm_regs_pkg::*;
    import rsa_pkg::*;
(
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest,
    output logic        start,
    output rsa_job_t    job,
    input  logic        done,
    input  rsa_word_t   result
);

    typedef enum logic [2:0] {
        s_get_n,
        s_get_d,
        s_get_data,
        s_req,
        s_wait,
        s_send
    } state_t;

    typedef enum logic {
        io_wait,  // polling status
        io_work   // data transfer in flight
    } io_state_t;

    state_t                       state, state_nx;
    io_state_t                    ios, ios_nx;
    logic [$clog2(rsa_bytes)-1:0] byte_cnt, byte_cnt_nx;
    avm_cmd_t                     cmd, cmd_nx;
    rsa_job_t                     job_q, job_nx;
    rsa_word_t                    plain, plain_nx;
    logic                         accepted;
    logic                         last_in;
    logic                         last_out;
    logic [7:0]                   rx_byte;

    assign accepted = (cmd.read | cmd.write) & ~avm_waitrequest;
    assign last_in  = (byte_cnt == ($clog2(rsa_bytes))'(rsa_bytes - 1));
    assign last_out = (byte_cnt == ($clog2(rsa_bytes))'(rsa_out_bytes - 1));
    assign rx_byte  = avm_readdata[7:0];

    assign avm_address   = cmd.address;
    assign avm_read      = cmd.read;
    assign avm_write     = cmd.write;
    assign avm_writedata = cmd.writedata;
    assign start         = (state == s_req);  // one cycle, right after the last byte
    assign job           = job_q;

    always_comb begin
        state_nx    = state;
        ios_nx      = ios;
        byte_cnt_nx = byte_cnt;
        cmd_nx      = cmd;
        job_nx      = job_q;
        plain_nx    = plain;

        case (state)
            s_get_n, s_get_d, s_get_data: begin
                if (ios == io_wait) begin
                    if (!cmd.read) begin
                        cmd_nx = cmd_status_rd;  // bus idle, start polling
                    end else if (accepted && avm_readdata[rx_ok_bit]) begin
                        cmd_nx = cmd_rx_rd;
                        ios_nx = io_work;
                    end
                end else if (accepted) begin
                    cmd_nx = cmd_status_rd;
                    ios_nx = io_wait;
                    // msb first, so shift in from the bottom
                    case (state)
                        s_get_n: job_nx.n = {job_q.n[rsa_width-9:0], rx_byte};
                        s_get_d: job_nx.d = {job_q.d[rsa_width-9:0], rx_byte};
                        default: job_nx.a = {job_q.a[rsa_width-9:0], rx_byte};
                    endcase
                    if (last_in) begin
                        byte_cnt_nx = '0;
                        case (state)
                            s_get_n: state_nx = s_get_d;
                            s_get_d: state_nx = s_get_data;
                            default: begin
                                state_nx = s_req;
                                cmd_nx   = cmd_idle;  // bus quiet while the core runs
                            end
                        endcase
                    end else begin
                        byte_cnt_nx = byte_cnt + 1'b1;
                    end
                end
            end
            s_req: begin
                state_nx = s_wait;
            end
            s_wait: begin
                if (done) begin
                    plain_nx = result;
                    state_nx = s_send;
                end
            end
            s_send: begin
                if (ios == io_wait) begin
                    if (!cmd.read) begin
                        cmd_nx = cmd_status_rd;
                    end else if (accepted && avm_readdata[tx_ok_bit]) begin
                        cmd_nx = '{address: tx_base, read: 1'b0, write: 1'b1,
                                   writedata: {24'd0, plain[rsa_width-9 -: 8]}};
                        ios_nx = io_work;
                    end
                end else if (accepted) begin
                    cmd_nx   = cmd_status_rd;
                    ios_nx   = io_wait;
                    plain_nx = {plain[rsa_width-9:0], 8'd0};
                    if (last_out) begin
                        byte_cnt_nx = '0;
                        state_nx    = s_get_data;  // same key, next ciphertext
                    end else begin
                        byte_cnt_nx = byte_cnt + 1'b1;
                    end
                end
            end
            default: state_nx = s_get_n;
        endcase
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state    <= s_get_n;
            ios      <= io_wait;
            byte_cnt <= '0;
            cmd      <= cmd_idle;
        end else begin
            state    <= state_nx;
            ios      <= ios_nx;
            byte_cnt <= byte_cnt_nx;
            cmd      <= cmd_nx;
        end
    end

    always_ff @(posedge avm_clk) begin
        job_q <= job_nx;
        plain <= plain_nx;
    end

endmodule

`default_nettype wire

/* src/rsa_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rsa_core
    import rsa_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    input  logic      start,
    input  rsa_job_t  job,
    output rsa_word_t result,
    output logic      done
);

    typedef enum logic [1:0] {
        c_idle,
        c_prep,
        c_loop
    } core_state_t;

    core_state_t                  state;
    logic [$clog2(rsa_width)-1:0] bit_idx;  // exponent bit under work
    logic                         prep_start;
    logic                         prep_done;
    logic                         mont_start;
    logic                         mul_done;
    logic                         sqr_done;
    logic                         pair_done;
    rsa_word_t                    prep_y;
    rsa_word_t                    mul_p;
    rsa_word_t                    sqr_p;
    rsa_word_t                    base;     // ciphertext power, montgomery domain
    rsa_word_t                    acc;      // running plaintext, normal domain

    assign prep_start = start && (state == c_idle);  // start while busy is dropped
    assign pair_done  = mul_done & sqr_done;
    assign result     = acc;

    rsa_prep u_prep (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prep_start),
        .a       (job.a),
        .n       (job.n),
        .y       (prep_y),
        .done    (prep_done)
    );

    // acc * base * R^-1 keeps acc out of the montgomery domain
    rsa_mont u_mont_mul (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mont_start),
        .a       (base),
        .b       (acc),
        .n       (job.n),
        .p       (mul_p),
        .done    (mul_done)
    );

    rsa_mont u_mont_sqr (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mont_start),
        .a       (base),
        .b       (base),
        .n       (job.n),
        .p       (sqr_p),
        .done    (sqr_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= c_idle;
            bit_idx    <= '0;
            mont_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            done       <= 1'b0;
            mont_start <= 1'b0;
            case (state)
                c_idle: begin
                    if (start) state <= c_prep;
                end
                c_prep: begin
                    if (prep_done) begin
                        state      <= c_loop;
                        bit_idx    <= '0;
                        mont_start <= 1'b1;
                    end
                end
                c_loop: begin
                    if (pair_done) begin
                        if (bit_idx == '1) begin  // last exponent bit
                            state <= c_idle;
                            done  <= 1'b1;
                        end else begin
                            bit_idx    <= bit_idx + 1'b1;
                            mont_start <= 1'b1;
                        end
                    end
                end
                default: state <= c_idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == c_prep && prep_done) begin
            base <= prep_y;
            acc  <= rsa_word_t'(1);
        end else if (state == c_loop && pair_done) begin
            base <= sqr_p;
            if (job.d[bit_idx]) acc <= mul_p;
        end
    end

endmodule

`default_nettype wire

/* src/rsa_mont.sv */
`timescale 1ns/10ps
`default_nettype none

module rsa_mont
    import rsa_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    input  logic      start,
    input  rsa_word_t a,
    input  rsa_word_t b,
    input  rsa_word_t n,
    output rsa_word_t p,
    output logic      done
);

    logic [rsa_width+1:0]         m;        // partial result, stays below 2n
    logic [rsa_width+1:0]         sum;
    logic [rsa_width+1:0]         odd_fix;
    logic [rsa_width+1:0]         half;
    logic [rsa_width+1:0]         fin;
    logic [rsa_width+1:0]         n_ext;
    rsa_word_t                    a_sh;     // multiplier bits, lsb first
    logic [$clog2(rsa_width)-1:0] step;
    logic                         busy;

    assign n_ext   = {2'b00, n};
    assign sum     = a_sh[0] ? m + {2'b00, b} : m;
    assign odd_fix = sum[0] ? sum + n_ext : sum;  // make it even so the halving is exact
    assign half    = odd_fix >> 1;
    assign fin     = (half >= n_ext) ? half - n_ext : half;
    assign p       = m[rsa_width-1:0];

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                step <= step + 1'b1;
                if (step == '1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (start) begin
                busy <= 1'b1;
                step <= '0;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (!busy && start) begin
            m    <= '0;
            a_sh <= a;
        end else if (busy) begin
            a_sh <= a_sh >> 1;
            m    <= (step == '1) ? fin : half;  // reduce below n on the last step
        end
    end

endmodule

`default_nettype wire

/* src/rsa_prep.sv */
`timescale 1ns/10ps
`default_nettype none

module rsa_prep
    import rsa_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    input  logic      start,
    input  rsa_word_t a,
    input  rsa_word_t n,
    output rsa_word_t y,
    output logic      done
);

    logic [rsa_width+1:0]         acc;    // two spare bits for the doubled value
    logic [rsa_width+1:0]         twice;
    logic [rsa_width+1:0]         dbl;
    logic [rsa_width+1:0]         n_ext;
    logic [$clog2(rsa_width)-1:0] step;
    logic                         busy;

    assign n_ext = {2'b00, n};
    assign twice = {acc[rsa_width:0], 1'b0};
    assign dbl   = (twice >= n_ext) ? twice - n_ext : twice;  // 2*acc mod n
    assign y     = acc[rsa_width-1:0];

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                step <= step + 1'b1;
                if (step == '1) begin  // 256th doubling
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (start) begin
                busy <= 1'b1;
                step <= '0;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (!busy && start) begin
            acc <= {2'b00, a};
        end else if (busy) begin
            acc <= dbl;
        end
    end

endmodule

`default_nettype wire

/* src/rsa_pkg.sv */
`default_nettype none

package rsa_pkg;

    localparam int rsa_width     = 256;
    localparam int rsa_bytes     = rsa_width / 8;
    localparam int rsa_out_bytes = rsa_bytes - 1;  // top byte of plaintext is not returned

    typedef logic [rsa_width-1:0] rsa_word_t;

    // key and ciphertext as collected by the wrapper
    typedef struct packed {
        rsa_word_t n;
        rsa_word_t d;
        rsa_word_t a;
    } rsa_job_t;

endpackage

`default_nettype wire

/* src/avm_regs_pkg.sv */
`default_nettype none

package avm_regs_pkg;

    // peripheral register byte offsets
    localparam logic [4:0] rx_base     = 5'd0;
    localparam logic [4:0] tx_base     = 5'd4;
    localparam logic [4:0] status_base = 5'd8;

    localparam int tx_ok_bit = 6;  // tx holding register free
    localparam int rx_ok_bit = 7;  // rx byte waiting

    typedef struct packed {
        logic [4:0]  address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } avm_cmd_t;

    localparam avm_cmd_t cmd_idle      = '{address: status_base, read: 1'b0, write: 1'b0,
                                           writedata: 32'd0};
    localparam avm_cmd_t cmd_status_rd = '{address: status_base, read: 1'b1, write: 1'b0,
                                           writedata: 32'd0};
    localparam avm_cmd_t cmd_rx_rd     = '{address: rx_base, read: 1'b1, write: 1'b0,
                                           writedata: 32'd0};

endpackage

`default_nettype wire
